// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_lfb_top
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_ARGS  = +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim.f ====
verilog/lfb_pkg.sv
verilog/lfb_alloc.sv
verilog/lfb_addr_entry.sv
verilog/lfb_merge.sv
verilog/lfb_addr_top.sv
tb/lfb_assert.sv
tb/tb_lfb_top.sv

// ==== tb/lfb_assert.sv ====
//==================================================
// line fill buffer assertions
// bound to the address side top level, keeps a
// small shadow of the entry attributes
//==================================================
`timescale 1ns/1ps

module lfb_assert #(
  parameter int entry_num  = 8,
  parameter int pfu_id_num = 9
) (
  input logic                         lfb_addr_entry_clk,
  input logic                         cpurst_b,
  input lfb_pkg::lfb_create_req_t     create_req,
  input logic                         pop_vld,
  input logic [lfb_pkg::id_w-1:0]     pop_id,
  input lfb_pkg::lfb_rcl_info_t       rcl_info,
  input logic                         vb_grnt,
  input logic                         dcache_en,
  input logic                         lm_already_snoop,
  input logic [lfb_pkg::idx_w-1:0]    ld_da_idx,
  input lfb_pkg::paddr_u              st_da_addr,
  input logic                         ld_da_discard_grnt,
  input logic                         full,
  input logic [lfb_pkg::id_w-1:0]     create_id,
  input logic [entry_num-1:0]         entry_vld,
  input logic                         vb_pe_req,
  input logic [lfb_pkg::id_w-1:0]     vb_req_id,
  input logic [entry_num-1:0]         linefill_permit,
  input logic [entry_num-1:0]         linefill_abort,
  input logic [entry_num-1:0]         depd,
  input logic [entry_num-1:0]         refill_way,
  input logic [pfu_id_num-1:0]        pfu_dcache_hit,
  input logic [pfu_id_num-1:0]        pfu_dcache_miss,
  input logic                         ld_da_hit_idx,
  input logic                         st_da_hit_idx,
  input logic                         discard_vld
);

  int                           fail_cnt = 0;
  logic                         sh_atomic [entry_num];
  logic                         sh_pfu [entry_num];
  logic [lfb_pkg::pfu_id_w-1:0] sh_pfu_id [entry_num];
  logic [lfb_pkg::idx_w-1:0]    sh_idx [entry_num];
  logic [entry_num-1:0]         sh_vld;
  logic [entry_num-1:0]         sh_granted;
  logic                         chk_vld;
  logic [lfb_pkg::id_w-1:0]     chk_id;
  logic                         chk_hit;
  logic                         chk_way;
  logic [entry_num-1:0]         ld_match;
  logic [entry_num-1:0]         st_match;
  logic                         exp_permit;
  logic                         exp_abort;
  logic                         aa;
  logic [pfu_id_num-1:0]        exp_vec;

  //==================================================
  // shadow of the entry attributes
  //==================================================
  always_ff @(posedge lfb_addr_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      sh_vld     <= '0;
      sh_granted <= '0;
      chk_vld    <= 1'b0;
      chk_id     <= '0;
      chk_hit    <= 1'b0;
      chk_way    <= 1'b0;
    end
    else
    begin
      if (vb_grnt && vb_pe_req)
        sh_granted[vb_req_id] <= 1'b1;
      if (create_req.vld && !full)
      begin
        sh_vld[create_id]     <= 1'b1;
        sh_granted[create_id] <= !dcache_en;
        sh_atomic[create_id]  <= create_req.atomic;
        sh_pfu[create_id]     <= create_req.pfu;
        sh_pfu_id[create_id]  <= create_req.pfu_id;
        sh_idx[create_id]     <= create_req.addr.fld.idx;
      end
      // pop wins over create
      if (pop_vld)
        sh_vld[pop_id] <= 1'b0;
      chk_vld <= rcl_info.vld && entry_vld[rcl_info.id];
      chk_id  <= rcl_info.id;
      chk_hit <= rcl_info.hit;
      chk_way <= rcl_info.way;
    end
  end

  always_comb
  begin
    for (int i = 0; i < entry_num; i++)
    begin
      ld_match[i] = entry_vld[i] && (sh_idx[i] == ld_da_idx);
      st_match[i] = entry_vld[i] && (sh_idx[i] == st_da_addr.fld.idx);
    end
    // linefill rule from the attributes sent at create
    aa         = !lm_already_snoop && chk_hit;
    exp_permit = !chk_hit || (sh_atomic[chk_id] && !aa);
    exp_abort  = chk_hit && (sh_pfu[chk_id] || (sh_atomic[chk_id] && aa));
    exp_vec    = pfu_id_num'(1) << sh_pfu_id[chk_id];
  end

  //==================================================
  // allocation and pop
  //==================================================
  a_lowest: assert property (@(posedge lfb_addr_entry_clk) disable iff (!cpurst_b)
    create_req.vld && !full |->
      (entry_num'(1) << create_id) == (~entry_vld & (entry_vld + 1'b1)))
    else begin fail_cnt++; $error("** Error %0t: create id not lowest free", $time); end

  a_alloc: assert property (@(posedge lfb_addr_entry_clk) disable iff (!cpurst_b)
    create_req.vld && !full |=> entry_vld[$past(create_id)])
    else begin fail_cnt++; $error("** Error %0t: created entry not valid", $time); end

  a_full: assert property (@(posedge lfb_addr_entry_clk) disable iff (!cpurst_b)
    full == (&sh_vld))
    else begin fail_cnt++; $error("** Error %0t: full mismatch", $time); end

  a_pop: assert property (@(posedge lfb_addr_entry_clk) disable iff (!cpurst_b)
    pop_vld |=> !entry_vld[$past(pop_id)])
    else begin fail_cnt++; $error("** Error %0t: popped entry still valid", $time); end

  a_depd_load: assert property (@(posedge lfb_addr_entry_clk) disable iff (!cpurst_b)
    create_req.vld && !full |=> depd[$past(create_id)] == $past(create_req.depd))
    else begin fail_cnt++; $error("** Error %0t: depd not loaded on create", $time); end

  //==================================================
  // victim request
  //==================================================
  a_req: assert property (@(posedge lfb_addr_entry_clk) disable iff (!cpurst_b)
    vb_pe_req == (|(entry_vld & ~sh_granted)))
    else begin fail_cnt++; $error("** Error %0t: vb_pe_req mismatch", $time); end

  a_drop: assert property (@(posedge lfb_addr_entry_clk) disable iff (!cpurst_b)
    vb_grnt && vb_pe_req |=> !(vb_pe_req && vb_req_id == $past(vb_req_id)))
    else begin fail_cnt++; $error("** Error %0t: granted request held", $time); end

  a_hold: assert property (@(posedge lfb_addr_entry_clk) disable iff (!cpurst_b)
    !vb_grnt && vb_pe_req && !pop_vld |=> vb_pe_req)
    else begin fail_cnt++; $error("** Error %0t: request lost under back-pressure", $time); end

  a_nodc: assert property (@(posedge lfb_addr_entry_clk) disable iff (!cpurst_b)
    create_req.vld && !full && !dcache_en |=> linefill_permit[$past(create_id)])
    else begin fail_cnt++; $error("** Error %0t: no permit with dcache off", $time); end

  //==================================================
  // linefill decision and prefetch reply
  //==================================================
  a_lf: assert property (@(posedge lfb_addr_entry_clk) disable iff (!cpurst_b)
    chk_vld |-> linefill_permit[chk_id] == exp_permit
                && linefill_abort[chk_id] == exp_abort)
    else begin fail_cnt++; $error("** Error %0t: linefill decision mismatch", $time); end

  a_way: assert property (@(posedge lfb_addr_entry_clk) disable iff (!cpurst_b)
    chk_vld |-> refill_way[chk_id] == chk_way)
    else begin fail_cnt++; $error("** Error %0t: refill way mismatch", $time); end

  a_pfu: assert property (@(posedge lfb_addr_entry_clk) disable iff (!cpurst_b)
    chk_vld && sh_pfu[chk_id] |->
      pfu_dcache_hit == (chk_hit ? exp_vec : '0)
      && pfu_dcache_miss == (chk_hit ? '0 : exp_vec))
    else begin fail_cnt++; $error("** Error %0t: prefetch reply mismatch", $time); end

  a_pfu_idle: assert property (@(posedge lfb_addr_entry_clk) disable iff (!cpurst_b)
    !(chk_vld && sh_pfu[chk_id]) |-> pfu_dcache_hit == '0 && pfu_dcache_miss == '0)
    else begin fail_cnt++; $error("** Error %0t: stray prefetch reply", $time); end

  //==================================================
  // index compares and discard
  //==================================================
  a_idx: assert property (@(posedge lfb_addr_entry_clk) disable iff (!cpurst_b)
    ld_da_hit_idx == (|ld_match) && st_da_hit_idx == (|st_match))
    else begin fail_cnt++; $error("** Error %0t: index hit mismatch", $time); end

  a_disc: assert property (@(posedge lfb_addr_entry_clk) disable iff (!cpurst_b)
    discard_vld == (ld_da_discard_grnt && (|ld_match)))
    else begin fail_cnt++; $error("** Error %0t: discard_vld mismatch", $time); end

  a_depd: assert property (@(posedge lfb_addr_entry_clk) disable iff (!cpurst_b)
    ld_da_discard_grnt |=> (depd & $past(ld_match)) == $past(ld_match))
    else begin fail_cnt++; $error("** Error %0t: depd not set on discard", $time); end

endmodule

bind lfb_addr_top lfb_assert #(
  .entry_num  (entry_num),
  .pfu_id_num (pfu_id_num)
) u_assert (
  .lfb_addr_entry_clk (lfb_addr_entry_clk),
  .cpurst_b           (cpurst_b),
  .create_req         (create_req),
  .pop_vld            (pop_vld),
  .pop_id             (pop_id),
  .rcl_info           (rcl_info),
  .vb_grnt            (vb_grnt),
  .dcache_en          (dcache_en),
  .lm_already_snoop   (lm_already_snoop),
  .ld_da_idx          (ld_da_idx),
  .st_da_addr         (st_da_addr),
  .ld_da_discard_grnt (ld_da_discard_grnt),
  .full               (full),
  .create_id          (create_id),
  .entry_vld          (entry_vld),
  .vb_pe_req          (vb_pe_req),
  .vb_req_id          (vb_req_id),
  .linefill_permit    (linefill_permit),
  .linefill_abort     (linefill_abort),
  .depd               (depd),
  .refill_way         (refill_way),
  .pfu_dcache_hit     (pfu_dcache_hit),
  .pfu_dcache_miss    (pfu_dcache_miss),
  .ld_da_hit_idx      (ld_da_hit_idx),
  .st_da_hit_idx      (st_da_hit_idx),
  .discard_vld        (discard_vld)
);

// ==== tb/tb_lfb_top.sv ====
//==================================================
// line fill buffer testbench
// seeded random creates, pops, victim results and
// discards; checking sits in the bound assertions
//==================================================
`timescale 1ns/1ps

module tb_lfb_top;

  localparam int entry_num  = 8;
  localparam int pfu_id_num = 9;
  localparam int max_wait   = 500;

  logic                         clk;
  logic                         cpurst_b;
  lfb_pkg::lfb_create_req_t     create_req;
  logic                         pop_vld;
  logic [lfb_pkg::id_w-1:0]     pop_id;
  lfb_pkg::lfb_rcl_info_t       rcl_info;
  logic                         vb_grnt;
  logic                         dcache_en;
  logic                         lm_already_snoop;
  logic [lfb_pkg::idx_w-1:0]    ld_da_idx;
  lfb_pkg::paddr_u              st_da_addr;
  logic                         ld_da_discard_grnt;
  logic                         full;
  logic [lfb_pkg::id_w-1:0]     create_id;
  logic [entry_num-1:0]         entry_vld;
  logic                         vb_pe_req;
  logic [lfb_pkg::id_w-1:0]     vb_req_id;
  logic [entry_num-1:0]         linefill_permit;
  logic [entry_num-1:0]         linefill_abort;
  logic [entry_num-1:0]         depd;
  logic [entry_num-1:0]         refill_way;
  logic [pfu_id_num-1:0]        pfu_dcache_hit;
  logic [pfu_id_num-1:0]        pfu_dcache_miss;
  logic                         ld_da_hit_idx;
  logic                         st_da_hit_idx;
  logic                         discard_vld;

  integer                       seed = 32'hc14507fe;
  int                           timeout_cnt = 0;
  int                           total;
  logic [entry_num-1:0]         rcl_sent;
  logic [lfb_pkg::idx_w-1:0]    tb_idx [entry_num];

  lfb_addr_top #(
    .entry_num  (entry_num),
    .pfu_id_num (pfu_id_num)
  ) uut (
    .lfb_addr_entry_clk (clk),
    .cpurst_b           (cpurst_b),
    .create_req         (create_req),
    .pop_vld            (pop_vld),
    .pop_id             (pop_id),
    .rcl_info           (rcl_info),
    .vb_grnt            (vb_grnt),
    .dcache_en          (dcache_en),
    .lm_already_snoop   (lm_already_snoop),
    .ld_da_idx          (ld_da_idx),
    .st_da_addr         (st_da_addr),
    .ld_da_discard_grnt (ld_da_discard_grnt),
    .full               (full),
    .create_id          (create_id),
    .entry_vld          (entry_vld),
    .vb_pe_req          (vb_pe_req),
    .vb_req_id          (vb_req_id),
    .linefill_permit    (linefill_permit),
    .linefill_abort     (linefill_abort),
    .depd               (depd),
    .refill_way         (refill_way),
    .pfu_dcache_hit     (pfu_dcache_hit),
    .pfu_dcache_miss    (pfu_dcache_miss),
    .ld_da_hit_idx      (ld_da_hit_idx),
    .st_da_hit_idx      (st_da_hit_idx),
    .discard_vld        (discard_vld)
  );

  always #5 clk = ~clk;

  // one clock edge, clears strobes and moves the random levels
  task automatic step();
    @(posedge clk);
    create_req.vld     <= 1'b0;
    pop_vld            <= 1'b0;
    rcl_info.vld       <= 1'b0;
    ld_da_discard_grnt <= 1'b0;
    vb_grnt            <= $random(seed);
    lm_already_snoop   <= $random(seed);
    st_da_addr.raw     <= {$random(seed), $random(seed)};
  endtask

  task automatic wait_not_full();
    int n;
    n = 0;
    @(negedge clk);
    while (full && n < max_wait)
    begin
      step();
      @(negedge clk);
      n++;
    end
    if (full)
    begin
      timeout_cnt++;
      $display("timeout: no free entry came up");
    end
  endtask

  task automatic wait_req_idle();
    int n;
    n = 0;
    @(negedge clk);
    while (vb_pe_req && n < max_wait)
    begin
      step();
      @(negedge clk);
      n++;
    end
    if (vb_pe_req)
    begin
      timeout_cnt++;
      $display("timeout: victim requests never drained");
    end
  endtask

  task automatic create_entry(input logic pfu);
    lfb_pkg::lfb_create_req_t req;
    int id;
    wait_not_full();
    id           = create_id;
    req.vld      = 1'b1;
    req.pfu      = pfu;
    req.addr.raw = {$random(seed), $random(seed)};
    req.atomic   = $random(seed);
    req.depd     = $random(seed);
    req.pfu_id   = ($random(seed) & 32'h7fff) % pfu_id_num;
    tb_idx[id]   = req.addr.fld.idx;
    rcl_sent[id] = 1'b0;
    step();
    create_req <= req;
    step();
  endtask

  task automatic send_rcl(input int id);
    rcl_sent[id] = 1'b1;
    step();
    rcl_info.vld <= 1'b1;
    rcl_info.id  <= lfb_pkg::id_w'(id);
    rcl_info.hit <= $random(seed);
    rcl_info.way <= $random(seed);
    step();
  endtask

  task automatic pop_entry(input int id);
    step();
    pop_vld <= 1'b1;
    pop_id  <= lfb_pkg::id_w'(id);
    step();
  endtask

  task automatic discard_on(input int id);
    step();
    ld_da_idx          <= tb_idx[id];
    ld_da_discard_grnt <= 1'b1;
    step();
  endtask

  initial
  begin
    int id;
    int op;
    clk                = 1'b0;
    cpurst_b           = 1'b0;
    create_req         = '0;
    pop_vld            = 1'b0;
    pop_id             = '0;
    rcl_info           = '0;
    vb_grnt            = 1'b0;
    dcache_en          = 1'b1;
    lm_already_snoop   = 1'b0;
    ld_da_idx          = '0;
    st_da_addr         = '0;
    ld_da_discard_grnt = 1'b0;
    rcl_sent           = '0;
    repeat (2) @(posedge clk);
    cpurst_b <= 1'b1;

    // fill up, let the victim requests drain, then answer each entry
    for (int i = 0; i < entry_num; i++)
      create_entry($random(seed));
    wait_req_idle();
    for (int i = 0; i < entry_num; i++)
    begin
      send_rcl(i);
      discard_on(i);
    end

    // random mix of traffic
    for (int k = 0; k < 120; k++)
    begin
      @(negedge clk);
      op = $random(seed) & 3;
      id = $random(seed) & 7;
      if (op == 0 && entry_vld[id])
        pop_entry(id);
      else if (op == 1 && !full)
        create_entry($random(seed));
      else if (op == 2 && entry_vld[id] && !rcl_sent[id])
        send_rcl(id);
      else if (entry_vld[id])
        discard_on(id);
      else
        step();
    end

    // dcache off, entries skip the victim buffer
    pop_entry(1);
    pop_entry(5);
    dcache_en <= 1'b0;
    create_entry(1'b0);
    create_entry(1'b0);
    step();
    dcache_en <= 1'b1;
    wait_req_idle();
    repeat (3) step();

    total = timeout_cnt + uut.u_assert.fail_cnt;
    $display("errors: %0d assertion, %0d timeout", uut.u_assert.fail_cnt, timeout_cnt);
    if (total == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== verilog/lfb_addr_entry.sv ====
//==================================================
// line fill buffer address entry
// holds one line address with its request flags,
// makes the linefill decision, the prefetch reply
// and the index compares
//==================================================
`timescale 1ns/1ps

module lfb_addr_entry #(
  parameter int pfu_id_num = 9
) (
  input  logic                         lfb_addr_entry_clk,
  input  logic                         cpurst_b,
  input  lfb_pkg::lfb_entry_ctrl_t     ctrl,
  input  lfb_pkg::lfb_create_req_t     create_req,
  input  lfb_pkg::lfb_rcl_info_t       rcl_info,
  input  logic                         vb_grnt,
  input  logic                         dcache_en,
  input  logic                         lm_already_snoop,
  input  logic [lfb_pkg::idx_w-1:0]    ld_da_idx,
  input  lfb_pkg::paddr_u              st_da_addr,
  input  logic                         ld_da_discard_grnt,
  output lfb_pkg::lfb_entry_stat_t     stat
);

  // index position inside the stored line address
  localparam int idx_lsb = lfb_pkg::line_offset_w - 4;

  logic                            vld;
  logic [lfb_pkg::pa_width-5:0]    line_addr;
  logic                            pfu_src;
  logic [lfb_pkg::pfu_id_w-1:0]    pfu_id;
  logic                            atomic;
  logic                            depd;
  logic                            vb_succ;
  logic                            rcl_done;
  logic                            dcache_hit;
  logic                            refill_way;
  logic                            already_reply;

  logic                            vb_req;
  logic                            atomic_abort;
  logic                            permit;
  logic                            abort;
  logic                            pfu_reply;
  logic                            ld_hit;
  logic                            st_hit;
  logic                            discard;

  //==================================================
  // entry registers
  //==================================================
  // pop wins over create
  always_ff @(posedge lfb_addr_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      vld <= 1'b0;
    else if (ctrl.pop)
      vld <= 1'b0;
    else if (ctrl.create)
      vld <= 1'b1;
  end

  // request payload
  always_ff @(posedge lfb_addr_entry_clk)
  begin
    if (ctrl.create)
    begin
      line_addr <= create_req.addr.raw[lfb_pkg::pa_width-1:4];
      pfu_src   <= create_req.pfu;
      pfu_id    <= create_req.pfu_id;
      atomic    <= create_req.atomic;
    end
  end

  always_ff @(posedge lfb_addr_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      depd <= 1'b0;
    else if (ctrl.create)
      depd <= create_req.depd;
    else if (discard)
      depd <= 1'b1;
  end

  // dcache off means no victim is needed
  always_ff @(posedge lfb_addr_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      vb_succ <= 1'b0;
    else if (ctrl.create)
      vb_succ <= !dcache_en;
    else if (vb_req && vb_grnt)
      vb_succ <= 1'b1;
  end

  // victim line check result
  always_ff @(posedge lfb_addr_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      rcl_done   <= 1'b0;
      dcache_hit <= 1'b0;
      refill_way <= 1'b0;
    end
    else if (ctrl.create)
    begin
      rcl_done   <= !dcache_en;
      dcache_hit <= 1'b0;
      refill_way <= 1'b0;
    end
    else if (ctrl.rcl_done)
    begin
      rcl_done   <= 1'b1;
      dcache_hit <= rcl_info.hit;
      refill_way <= rcl_info.way;
    end
  end

  // marks the prefetch reply as sent
  always_ff @(posedge lfb_addr_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      already_reply <= 1'b0;
    else if (ctrl.create)
      already_reply <= 1'b0;
    else if (rcl_done)
      already_reply <= 1'b1;
  end

  //==================================================
  // victim request and linefill decision
  //==================================================
  assign vb_req = vld && !vb_succ;

  // a hit line not yet snooped must not be refilled by an atomic
  assign atomic_abort = !lm_already_snoop && dcache_hit;
  assign permit       = rcl_done && (!dcache_hit || (atomic && !atomic_abort));
  assign abort        = rcl_done && dcache_hit && (pfu_src || (atomic && atomic_abort));

  //==================================================
  // prefetch reply and index compares
  //==================================================
  assign pfu_reply = vld && pfu_src && rcl_done && !already_reply;

  assign ld_hit  = vld && (line_addr[idx_lsb +: lfb_pkg::idx_w] == ld_da_idx);
  assign st_hit  = vld && (line_addr[idx_lsb +: lfb_pkg::idx_w] == st_da_addr.fld.idx);
  assign discard = ld_da_discard_grnt && ld_hit;

  always_comb
  begin
    stat            = '0;
    stat.vld        = vld;
    stat.vb_req     = vb_req;
    stat.permit     = permit;
    stat.abort      = abort;
    stat.depd       = depd;
    stat.refill_way = refill_way;
    stat.ld_hit     = ld_hit;
    stat.st_hit     = st_hit;
    stat.discard    = discard;
    // one-hot on the stored pfu id
    for (int k = 0; k < pfu_id_num; k++)
    begin
      stat.pfu_hit[k]  = pfu_reply && dcache_hit && (pfu_id == lfb_pkg::pfu_id_w'(k));
      stat.pfu_miss[k] = pfu_reply && !dcache_hit && (pfu_id == lfb_pkg::pfu_id_w'(k));
    end
  end

endmodule

// ==== verilog/lfb_addr_top.sv ====
//==================================================
// line fill buffer address side top level
// allocator, entry array and status merger
//==================================================
`timescale 1ns/1ps

module lfb_addr_top #(
  parameter int entry_num  = 8,
  parameter int pfu_id_num = 9
) (
  input  logic                         lfb_addr_entry_clk,
  input  logic                         cpurst_b,
  input  lfb_pkg::lfb_create_req_t     create_req,
  input  logic                         pop_vld,
  input  logic [lfb_pkg::id_w-1:0]     pop_id,
  input  lfb_pkg::lfb_rcl_info_t       rcl_info,
  input  logic                         vb_grnt,
  input  logic                         dcache_en,
  input  logic                         lm_already_snoop,
  input  logic [lfb_pkg::idx_w-1:0]    ld_da_idx,
  input  lfb_pkg::paddr_u              st_da_addr,
  input  logic                         ld_da_discard_grnt,
  output logic                         full,
  output logic [lfb_pkg::id_w-1:0]     create_id,
  output logic [entry_num-1:0]         entry_vld,
  output logic                         vb_pe_req,
  output logic [lfb_pkg::id_w-1:0]     vb_req_id,
  output logic [entry_num-1:0]         linefill_permit,
  output logic [entry_num-1:0]         linefill_abort,
  output logic [entry_num-1:0]         depd,
  output logic [entry_num-1:0]         refill_way,
  output logic [pfu_id_num-1:0]        pfu_dcache_hit,
  output logic [pfu_id_num-1:0]        pfu_dcache_miss,
  output logic                         ld_da_hit_idx,
  output logic                         st_da_hit_idx,
  output logic                         discard_vld
);

  lfb_pkg::lfb_entry_ctrl_t entry_ctrl [entry_num];
  lfb_pkg::lfb_entry_stat_t entry_stat [entry_num];
  logic [entry_num-1:0]     vb_grnt_oh;

  //==================================================
  // allocator
  //==================================================
  lfb_alloc #(
    .entry_num (entry_num)
  ) u_alloc (
    .lfb_addr_entry_clk (lfb_addr_entry_clk),
    .cpurst_b           (cpurst_b),
    .create_req         (create_req),
    .pop_vld            (pop_vld),
    .pop_id             (pop_id),
    .rcl_info           (rcl_info),
    .entry_vld          (entry_vld),
    .entry_ctrl         (entry_ctrl),
    .create_id          (create_id),
    .full               (full)
  );

  //==================================================
  // fill entries
  //==================================================
  for (genvar i = 0; i < entry_num; i++)
  begin : g_entry
    lfb_addr_entry #(
      .pfu_id_num (pfu_id_num)
    ) u_entry (
      .lfb_addr_entry_clk (lfb_addr_entry_clk),
      .cpurst_b           (cpurst_b),
      .ctrl               (entry_ctrl[i]),
      .create_req         (create_req),
      .rcl_info           (rcl_info),
      .vb_grnt            (vb_grnt_oh[i]),
      .dcache_en          (dcache_en),
      .lm_already_snoop   (lm_already_snoop),
      .ld_da_idx          (ld_da_idx),
      .st_da_addr         (st_da_addr),
      .ld_da_discard_grnt (ld_da_discard_grnt),
      .stat               (entry_stat[i])
    );
  end

  //==================================================
  // merger
  //==================================================
  lfb_merge #(
    .entry_num  (entry_num),
    .pfu_id_num (pfu_id_num)
  ) u_merge (
    .entry_stat      (entry_stat),
    .vb_grnt         (vb_grnt),
    .vb_grnt_oh      (vb_grnt_oh),
    .entry_vld       (entry_vld),
    .vb_pe_req       (vb_pe_req),
    .vb_req_id       (vb_req_id),
    .linefill_permit (linefill_permit),
    .linefill_abort  (linefill_abort),
    .depd            (depd),
    .refill_way      (refill_way),
    .pfu_dcache_hit  (pfu_dcache_hit),
    .pfu_dcache_miss (pfu_dcache_miss),
    .ld_da_hit_idx   (ld_da_hit_idx),
    .st_da_hit_idx   (st_da_hit_idx),
    .discard_vld     (discard_vld)
  );

endmodule

// ==== verilog/lfb_alloc.sv ====
//==================================================
// line fill buffer allocator
// picks the lowest free entry and decodes the
// pop and victim-result ids into entry strobes
//==================================================
`timescale 1ns/1ps

module lfb_alloc #(
  parameter int entry_num = 8
) (
  input  logic                           lfb_addr_entry_clk,
  input  logic                           cpurst_b,
  input  lfb_pkg::lfb_create_req_t       create_req,
  input  logic                           pop_vld,
  input  logic [lfb_pkg::id_w-1:0]       pop_id,
  input  lfb_pkg::lfb_rcl_info_t         rcl_info,
  input  logic [entry_num-1:0]           entry_vld,
  output lfb_pkg::lfb_entry_ctrl_t       entry_ctrl [entry_num],
  output logic [lfb_pkg::id_w-1:0]       create_id,
  output logic                           full
);

  logic create_ok;

  //==================================================
  // lowest free entry
  //==================================================
  always_comb
  begin
    create_id = '0;
    // walk down so the lowest free index wins
    for (int i = entry_num - 1; i >= 0; i--)
    begin
      if (!entry_vld[i])
      begin
        create_id = lfb_pkg::id_w'(i);
      end
    end
  end

  assign full      = &entry_vld;
  assign create_ok = create_req.vld && !full;

  //==================================================
  // per-entry strobe decode
  //==================================================
  always_comb
  begin
    for (int i = 0; i < entry_num; i++)
    begin
      entry_ctrl[i].create   = create_ok && (create_id == lfb_pkg::id_w'(i));
      entry_ctrl[i].pop      = pop_vld && (pop_id == lfb_pkg::id_w'(i));
      entry_ctrl[i].rcl_done = rcl_info.vld && (rcl_info.id == lfb_pkg::id_w'(i));
    end
  end

endmodule

// ==== verilog/lfb_merge.sv ====
//==================================================
// line fill buffer status merger
// gathers the entry status into vectors, ORs the
// hit and prefetch vectors and arbitrates victim
// buffer requests, lowest index first
//==================================================
`timescale 1ns/1ps

module lfb_merge #(
  parameter int entry_num  = 8,
  parameter int pfu_id_num = 9
) (
  input  lfb_pkg::lfb_entry_stat_t     entry_stat [entry_num],
  input  logic                         vb_grnt,
  output logic [entry_num-1:0]         vb_grnt_oh,
  output logic [entry_num-1:0]         entry_vld,
  output logic                         vb_pe_req,
  output logic [lfb_pkg::id_w-1:0]     vb_req_id,
  output logic [entry_num-1:0]         linefill_permit,
  output logic [entry_num-1:0]         linefill_abort,
  output logic [entry_num-1:0]         depd,
  output logic [entry_num-1:0]         refill_way,
  output logic [pfu_id_num-1:0]        pfu_dcache_hit,
  output logic [pfu_id_num-1:0]        pfu_dcache_miss,
  output logic                         ld_da_hit_idx,
  output logic                         st_da_hit_idx,
  output logic                         discard_vld
);

  logic [entry_num-1:0] req_oh;

  //==================================================
  // status vectors and OR trees
  //==================================================
  always_comb
  begin
    pfu_dcache_hit  = '0;
    pfu_dcache_miss = '0;
    ld_da_hit_idx   = 1'b0;
    st_da_hit_idx   = 1'b0;
    discard_vld     = 1'b0;
    for (int i = 0; i < entry_num; i++)
    begin
      entry_vld[i]       = entry_stat[i].vld;
      linefill_permit[i] = entry_stat[i].permit;
      linefill_abort[i]  = entry_stat[i].abort;
      depd[i]            = entry_stat[i].depd;
      refill_way[i]      = entry_stat[i].refill_way;
      pfu_dcache_hit     = pfu_dcache_hit | entry_stat[i].pfu_hit[pfu_id_num-1:0];
      pfu_dcache_miss    = pfu_dcache_miss | entry_stat[i].pfu_miss[pfu_id_num-1:0];
      ld_da_hit_idx      = ld_da_hit_idx | entry_stat[i].ld_hit;
      st_da_hit_idx      = st_da_hit_idx | entry_stat[i].st_hit;
      discard_vld        = discard_vld | entry_stat[i].discard;
    end
  end

  //==================================================
  // victim buffer request arbitration
  //==================================================
  // fixed priority, scanned downward so the lowest wins
  always_comb
  begin
    vb_pe_req = 1'b0;
    vb_req_id = '0;
    req_oh    = '0;
    for (int i = entry_num - 1; i >= 0; i--)
    begin
      if (entry_stat[i].vb_req)
      begin
        vb_pe_req = 1'b1;
        vb_req_id = lfb_pkg::id_w'(i);
        req_oh    = '0;
        req_oh[i] = 1'b1;
      end
    end
  end

  // grant only while the victim buffer accepts
  assign vb_grnt_oh = vb_grnt ? req_oh : '0;

endmodule

// ==== verilog/lfb_pkg.sv ====
//==================================================
// line fill buffer shared definitions
// address widths, the address union and the
// request, victim-result and entry-status structs
//==================================================

package lfb_pkg;

  // address geometry
  localparam int pa_width      = 40;
  localparam int line_offset_w = 6;
  localparam int idx_w         = 8;
  localparam int tag_w         = pa_width - idx_w - line_offset_w;

  // id widths
  localparam int id_w      = 3;
  localparam int pfu_id_w  = 4;
  // room for the prefetch reply vectors
  localparam int pfu_vec_w = 9;

  //==================================================
  // physical address, raw or split into fields
  //==================================================
  typedef struct packed {
    logic [tag_w-1:0]         tag;
    logic [idx_w-1:0]         idx;
    logic [line_offset_w-1:0] offset;
  } paddr_fields_t;

  typedef union packed {
    logic [pa_width-1:0] raw;
    paddr_fields_t       fld;
  } paddr_u;

  //==================================================
  // request and status structs
  //==================================================
  // create request from rb or pfu
  typedef struct packed {
    logic                vld;
    logic                pfu;
    paddr_u              addr;
    logic                atomic;
    logic                depd;
    logic [pfu_id_w-1:0] pfu_id;
  } lfb_create_req_t;

  // victim line check result
  typedef struct packed {
    logic            vld;
    logic [id_w-1:0] id;
    logic            hit;
    logic            way;
  } lfb_rcl_info_t;

  // per-entry strobes
  typedef struct packed {
    logic create;
    logic pop;
    logic rcl_done;
  } lfb_entry_ctrl_t;

  // per-entry status toward the merger
  typedef struct packed {
    logic                 vld;
    logic                 vb_req;
    logic                 permit;
    logic                 abort;
    logic                 depd;
    logic                 refill_way;
    logic                 ld_hit;
    logic                 st_hit;
    logic                 discard;
    logic [pfu_vec_w-1:0] pfu_hit;
    logic [pfu_vec_w-1:0] pfu_miss;
  } lfb_entry_stat_t;

endpackage
